/* src/uart_dbg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared sizes, protocol byte codes and bus structs of the UART debug
// loader. Modules import it inside their body; port types use scoped names
////////////////////////////////////////////////////////////////////////////

package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Clock cycles per UART bit, kept low for fast simulation
  localparam int CLKS_PER_BIT = 16;
  // Width of the oversampling counters
  localparam int CNT_W        = $clog2(CLKS_PER_BIT);

  localparam int ADDR_W       = 32;
  localparam int ADDR_BYTES   = 4;
  localparam int LEN_BYTES    = 2;
  localparam int LEN_W        = 16;
  localparam int EXIT_BYTES   = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Protocol bytes
  ////////////////////////////////////////////////////////////////////////////

  // Reply and challenge markers
  localparam logic [7:0] BYTE_ACK = 8'h06;
  localparam logic [7:0] BYTE_EOT = 8'h04;
  localparam logic [7:0] BYTE_EOC = 8'h14;

  // Command bytes that open a framed request
  typedef enum logic [7:0] {
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13
  } dbg_cmd_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // One received byte, valid for a single cycle
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_strm_t;

  // Single-byte memory request from the engine
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
  } bus_req_t;

  // APB request, byte wide
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [7:0]        pwdata;
  } apb_req_t;

  // APB response, no error bit
  typedef struct packed {
    logic       pready;
    logic [7:0] prdata;
  } apb_rsp_t;

endpackage

/* src/uart_rx.sv */
////////////////////////////////////////////////////////////////////////////
// UART receiver, 8N1. Samples the line mid-bit and emits each good byte
// as a one-cycle strobe; frames with a low stop bit are dropped
////////////////////////////////////////////////////////////////////////////

module uart_rx (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  logic                    rx_i,
  output uart_dbg_pkg::byte_strm_t byte_o
);
  import uart_dbg_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e        state_q;
  logic [1:0]       sync_q;
  logic [CNT_W-1:0] cyc_cnt_q;
  logic [2:0]       bit_cnt_q;
  logic [7:0]       shift_q;
  logic             valid_q;
  logic             rx;

  // Two-flop synchronizer on the asynchronous line
  assign rx = sync_q[1];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= RX_IDLE;
      sync_q    <= 2'b11;
      cyc_cnt_q <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      valid_q   <= 1'b0;
      cyc_cnt_q <= cyc_cnt_q + CNT_W'(1);
      case (state_q)
        RX_IDLE: begin
          cyc_cnt_q <= '0;
          if (!rx) state_q <= RX_START;
        end
        // Half a bit into the start bit, glitches go back to idle
        RX_START: if (cyc_cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
          cyc_cnt_q <= '0;
          bit_cnt_q <= '0;
          state_q   <= rx ? RX_IDLE : RX_DATA;
        end
        RX_DATA: if (cyc_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
          if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
        end
        RX_STOP: if (cyc_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
          valid_q <= rx;
          state_q <= RX_IDLE;
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && cyc_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
      shift_q <= {rx, shift_q[7:1]};
    end
  end

  assign byte_o = '{valid: valid_q, data: shift_q};

  // The engine relies on strobes being separated
  assert property (@(posedge clk) disable iff (!arst_n_i) byte_o.valid |=> !byte_o.valid)
    else $error("uart_rx: byte strobe held for two cycles");

endmodule

/* src/uart_tx.sv */
////////////////////////////////////////////////////////////////////////////
// UART transmitter, 8N1. Takes one byte on send_i while ready_o is high
// and raises ready_o again once the stop bit has gone out
////////////////////////////////////////////////////////////////////////////

module uart_tx (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       send_i,
  input  logic [7:0] data_i,
  output logic       ready_o,
  output logic       tx_o
);
  import uart_dbg_pkg::*;

  logic [9:0]       frame_q;
  logic [CNT_W-1:0] cyc_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic             bit_end;

  assign bit_end = (cyc_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_o   <= 1'b1;
      cyc_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (ready_o) begin
      if (send_i) begin
        ready_o   <= 1'b0;
        cyc_cnt_q <= '0;
        bit_cnt_q <= '0;
      end
    end else if (bit_end) begin
      cyc_cnt_q <= '0;
      // Bit 9 is the stop bit
      if (bit_cnt_q == 4'd9) ready_o <= 1'b1;
      else bit_cnt_q <= bit_cnt_q + 4'd1;
    end else begin
      cyc_cnt_q <= cyc_cnt_q + CNT_W'(1);
    end
  end

  // Start bit in bit 0, stop bit on top
  always_ff @(posedge clk) begin
    if (ready_o && send_i) frame_q <= {1'b1, data_i, 1'b0};
    else if (!ready_o && bit_end) frame_q <= {1'b1, frame_q[9:1]};
  end

  // Line idles high
  assign tx_o = ready_o ? 1'b1 : frame_q[0];

  assert property (@(posedge clk) disable iff (!arst_n_i) send_i |-> ready_o)
    else $error("uart_tx: send while busy");

endmodule

/* src/apb_byte_master.sv */
////////////////////////////////////////////////////////////////////////////
// APB master for single-byte accesses. One request at a time is held on
// req_valid_i until done_o, which also carries the read data
////////////////////////////////////////////////////////////////////////////

module apb_byte_master (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   req_valid_i,
  input  uart_dbg_pkg::bus_req_t req_i,
  output logic                   done_o,
  output logic [7:0]             rdata_o,
  output uart_dbg_pkg::apb_req_t apb_o,
  input  uart_dbg_pkg::apb_rsp_t apb_i
);
  import uart_dbg_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} apb_state_e;

  apb_state_e state_q;
  bus_req_t   req_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:   if (req_valid_i) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;
        // Wait states last until the slave raises pready
        ST_ACCESS: if (apb_i.pready) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Captured once, so address and data hold through the access
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && req_valid_i) req_q <= req_i;
  end

  assign apb_o = '{
    psel:    (state_q != ST_IDLE),
    penable: (state_q == ST_ACCESS),
    pwrite:  req_q.write,
    paddr:   req_q.addr,
    pwdata:  req_q.wdata
  };

  // Done in the cycle the access completes, so the engine can
  // drop its request on the same edge
  assign done_o  = (state_q == ST_ACCESS) && apb_i.pready;
  assign rdata_o = apb_i.prdata;

  // The engine keeps its request up for the whole transfer
  assert property (@(posedge clk) disable iff (!arst_n_i)
    apb_o.psel |-> req_valid_i)
    else $error("apb_byte_master: request dropped during a transfer");

endmodule

/* src/dbg_cmd_engine.sv */
////////////////////////////////////////////////////////////////////////////
// Debug protocol engine. Decodes host commands from the receiver, runs
// byte-wise bus bursts and builds the replies for the transmitter
////////////////////////////////////////////////////////////////////////////

module dbg_cmd_engine (
  input  logic                                    clk,
  input  logic                                    arst_n_i,
  input  uart_dbg_pkg::byte_strm_t                rx_byte_i,
  output logic                                    tx_send_o,
  output logic [7:0]                              tx_data_o,
  input  logic                                    tx_ready_i,
  output logic                                    bus_valid_o,
  output uart_dbg_pkg::bus_req_t                  bus_req_o,
  input  logic                                    bus_done_i,
  input  logic [7:0]                              bus_rdata_i,
  output logic                                    exec_valid_o,
  output logic [uart_dbg_pkg::ADDR_W-1:0]         exec_addr_o,
  input  logic                                    eoc_i,
  input  logic [8*uart_dbg_pkg::EXIT_BYTES-1:0]   exit_code_i
);
  import uart_dbg_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE, ST_ADDR, ST_LEN, ST_ACK_END, ST_ACK_BURST, ST_WR_WAIT, ST_WR_BUS,
    ST_RD_BUS, ST_RD_SEND, ST_EOT, ST_EOC, ST_CODE
  } eng_state_e;

  eng_state_e                  state_q;
  logic [1:0]                  cnt_q;
  logic                        eoc_pend_q;
  logic                        exec_valid_q;
  dbg_cmd_e                    cmd_q;
  logic [ADDR_W-1:0]           addr_q;
  logic [LEN_W-1:0]            len_q;
  logic [7:0]                  wdata_q;
  logic [7:0]                  rdata_q;
  logic [8*EXIT_BYTES-1:0]     code_q;
  logic                        rx_valid;

  assign rx_valid = rx_byte_i.valid;

  ////////////////////////////////////////////////////////////////////////////
  // Reply byte selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    tx_data_o = BYTE_ACK;
    tx_send_o = 1'b0;
    case (state_q)
      ST_ACK_END, ST_ACK_BURST: tx_send_o = tx_ready_i;
      ST_RD_SEND: begin
        tx_data_o = rdata_q;
        tx_send_o = tx_ready_i;
      end
      ST_EOT: begin
        tx_data_o = BYTE_EOT;
        tx_send_o = tx_ready_i;
      end
      ST_EOC: begin
        tx_data_o = BYTE_EOC;
        tx_send_o = tx_ready_i;
      end
      // Exit code goes out LSB first
      ST_CODE: begin
        tx_data_o = code_q[7:0];
        tx_send_o = tx_ready_i;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= ST_IDLE;
      cnt_q        <= '0;
      eoc_pend_q   <= 1'b0;
      exec_valid_q <= 1'b0;
    end else begin
      exec_valid_q <= 1'b0;
      if (eoc_i) eoc_pend_q <= 1'b1;
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (rx_valid) begin
            case (rx_byte_i.data)
              BYTE_ACK:                      state_q <= ST_ACK_END;
              CMD_READ, CMD_WRITE, CMD_EXEC: state_q <= ST_ADDR;
              default: ;
            endcase
          end else if (eoc_pend_q) begin
            // End of computation is only reported between commands
            eoc_pend_q <= eoc_i;
            state_q    <= ST_EOC;
          end
        end
        ST_ADDR: if (rx_valid) begin
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == 2'(ADDR_BYTES - 1)) begin
            cnt_q <= '0;
            if (cmd_q == CMD_EXEC) begin
              exec_valid_q <= 1'b1;
              state_q      <= ST_ACK_END;
            end else begin
              state_q <= ST_LEN;
            end
          end
        end
        ST_LEN: if (rx_valid) begin
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == 2'(LEN_BYTES - 1)) state_q <= ST_ACK_BURST;
        end
        ST_ACK_END: if (tx_send_o) state_q <= ST_IDLE;
        ST_ACK_BURST: if (tx_send_o) begin
          if (len_q == '0) state_q <= ST_EOT;
          else if (cmd_q == CMD_READ) state_q <= ST_RD_BUS;
          else state_q <= ST_WR_WAIT;
        end
        ST_WR_WAIT: if (rx_valid) state_q <= ST_WR_BUS;
        ST_WR_BUS: if (bus_done_i) begin
          state_q <= (len_q == LEN_W'(1)) ? ST_EOT : ST_WR_WAIT;
        end
        ST_RD_BUS: if (bus_done_i) state_q <= ST_RD_SEND;
        ST_RD_SEND: if (tx_send_o) begin
          state_q <= (len_q == LEN_W'(1)) ? ST_EOT : ST_RD_BUS;
        end
        ST_EOT: if (tx_send_o) state_q <= ST_IDLE;
        ST_EOC: if (tx_send_o) begin
          cnt_q   <= '0;
          state_q <= ST_CODE;
        end
        ST_CODE: if (tx_send_o) begin
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == 2'(EXIT_BYTES - 1)) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (state_q)
      ST_IDLE:    if (rx_valid) cmd_q <= dbg_cmd_e'(rx_byte_i.data);
      // Fields arrive LSB first, so shift in from the top
      ST_ADDR:    if (rx_valid) addr_q <= {rx_byte_i.data, addr_q[ADDR_W-1:8]};
      ST_LEN:     if (rx_valid) len_q <= {rx_byte_i.data, len_q[LEN_W-1:8]};
      ST_WR_WAIT: if (rx_valid) wdata_q <= rx_byte_i.data;
      ST_WR_BUS: if (bus_done_i) begin
        addr_q <= addr_q + ADDR_W'(1);
        len_q  <= len_q - LEN_W'(1);
      end
      ST_RD_BUS:  if (bus_done_i) rdata_q <= bus_rdata_i;
      ST_RD_SEND: if (tx_send_o) begin
        addr_q <= addr_q + ADDR_W'(1);
        len_q  <= len_q - LEN_W'(1);
      end
      ST_CODE:    if (tx_send_o) code_q <= code_q >> 8;
      default: ;
    endcase
    if (eoc_i) code_q <= exit_code_i;
  end

  assign bus_valid_o  = (state_q == ST_WR_BUS) || (state_q == ST_RD_BUS);
  assign bus_req_o    = '{write: (state_q == ST_WR_BUS), addr: addr_q, wdata: wdata_q};
  assign exec_valid_o = exec_valid_q;
  assign exec_addr_o  = addr_q;

  // A bus request stays put until the APB master completes it
  assert property (@(posedge clk) disable iff (!arst_n_i)
    bus_valid_o && !bus_done_i |=> bus_valid_o && $stable(bus_req_o))
    else $error("dbg_cmd_engine: bus request changed before done");

endmodule

/* src/uart_dbg_top.sv */
////////////////////////////////////////////////////////////////////////////
// UART debug loader top. Host commands come in on rx_i, memory is reached
// over the byte-wide APB port, replies leave on tx_o
////////////////////////////////////////////////////////////////////////////

module uart_dbg_top (
  input  logic                                  clk,
  input  logic                                  arst_n_i,
  input  logic                                  rx_i,
  output logic                                  tx_o,
  output uart_dbg_pkg::apb_req_t                apb_o,
  input  uart_dbg_pkg::apb_rsp_t                apb_i,
  output logic                                  exec_valid_o,
  output logic [uart_dbg_pkg::ADDR_W-1:0]       exec_addr_o,
  input  logic                                  eoc_i,
  input  logic [8*uart_dbg_pkg::EXIT_BYTES-1:0] exit_code_i
);
  import uart_dbg_pkg::*;

  byte_strm_t rx_byte;
  logic       tx_send;
  logic [7:0] tx_data;
  logic       tx_ready;
  logic       bus_valid;
  bus_req_t   bus_req;
  logic       bus_done;
  logic [7:0] bus_rdata;

  uart_rx i_uart_rx (
    .clk      ( clk      ),
    .arst_n_i ( arst_n_i ),
    .rx_i     ( rx_i     ),
    .byte_o   ( rx_byte  )
  );

  uart_tx i_uart_tx (
    .clk      ( clk      ),
    .arst_n_i ( arst_n_i ),
    .send_i   ( tx_send  ),
    .data_i   ( tx_data  ),
    .ready_o  ( tx_ready ),
    .tx_o     ( tx_o     )
  );

  dbg_cmd_engine i_dbg_cmd_engine (
    .clk          ( clk          ),
    .arst_n_i     ( arst_n_i     ),
    .rx_byte_i    ( rx_byte      ),
    .tx_send_o    ( tx_send      ),
    .tx_data_o    ( tx_data      ),
    .tx_ready_i   ( tx_ready     ),
    .bus_valid_o  ( bus_valid    ),
    .bus_req_o    ( bus_req      ),
    .bus_done_i   ( bus_done     ),
    .bus_rdata_i  ( bus_rdata    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  ),
    .eoc_i        ( eoc_i        ),
    .exit_code_i  ( exit_code_i  )
  );

  apb_byte_master i_apb_byte_master (
    .clk         ( clk       ),
    .arst_n_i    ( arst_n_i  ),
    .req_valid_i ( bus_valid ),
    .req_i       ( bus_req   ),
    .done_o      ( bus_done  ),
    .rdata_o     ( bus_rdata ),
    .apb_o       ( apb_o     ),
    .apb_i       ( apb_i     )
  );

endmodule

/* testbench/tb_clk_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Clock and reset source for the debug loader testbench. 100 ns clock,
// reset held low for the first 16 cycles
////////////////////////////////////////////////////////////////////////////

module tb_clk_gen (
  output logic clk,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Release just after an edge
  initial begin
    arst_n_o = 1'b0;
    repeat (16) @(posedge clk);
    #10;
    arst_n_o = 1'b1;
  end

endmodule

/* testbench/tb_uart_dbg.sv */
////////////////////////////////////////////////////////////////////////////
// Random test of the UART debug loader. A host task talks over rx, a
// monitor collects replies from tx, an APB slave model backs the memory
////////////////////////////////////////////////////////////////////////////

module tb_uart_dbg;
  timeunit 1ns;
  timeprecision 1ps;
  import uart_dbg_pkg::*;

  logic        clk;
  logic        arst_n;
  logic        rx;
  logic        tx;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        exec_valid;
  logic [31:0] exec_addr;
  logic        eoc;
  logic [31:0] exit_code;

  logic [31:0] rng_state = 32'h72aac8a7;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  logic [7:0]  reply_q[$];
  logic [7:0]  mon_byte;
  logic [7:0]  slave_mem[logic [31:0]];
  logic [7:0]  ref_mem[logic [31:0]];
  logic [31:0] wlog_addr[$];
  logic [7:0]  wlog_data[$];
  int          wait_left = 0;
  int          apb_access_cnt = 0;
  int          exec_pulses = 0;
  logic [31:0] exec_addr_seen = '0;

  // Test parameters drawn before reset
  logic [31:0] rnd;
  logic [31:0] wr_addr;
  int          wr_len;
  logic [7:0]  wr_data[16];
  logic [31:0] exec_target;
  logic [31:0] code;
  logic [7:0]  bad_cmd;
  int          access_before;

  tb_clk_gen i_tb_clk_gen (
    .clk      ( clk    ),
    .arst_n_o ( arst_n )
  );

  uart_dbg_top i_uart_dbg_top (
    .clk          ( clk        ),
    .arst_n_i     ( arst_n     ),
    .rx_i         ( rx         ),
    .tx_o         ( tx         ),
    .apb_o        ( apb_req    ),
    .apb_i        ( apb_rsp    ),
    .exec_valid_o ( exec_valid ),
    .exec_addr_o  ( exec_addr  ),
    .eoc_i        ( eoc        ),
    .exit_code_i  ( exit_code  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Contents of memory never written depend on every address bit
  function automatic logic [7:0] fill_byte(input logic [31:0] addr);
    return addr[31:24] ^ addr[23:16] ^ addr[15:8] ^ addr[7:0] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] pick_unknown_cmd();
    logic [31:0] r;
    logic [7:0]  b;
    r = lcg_next();
    b = r[15:8];
    while (b == BYTE_ACK || b == CMD_READ || b == CMD_WRITE || b == CMD_EXEC) begin
      r = lcg_next();
      b = r[15:8];
    end
    return b;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // 8N1 frame on the host line
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    @(posedge clk);
    #10;
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #10;
    end
  endtask

  // Multi-byte fields go LSB first
  task automatic send_field(input logic [31:0] value, input int nbytes);
    for (int i = 0; i < nbytes; i++) send_byte(value[8*i +: 8]);
  endtask

  task automatic expect_byte(input string name, input logic [7:0] exp);
    logic [7:0] got;
    while (reply_q.size() == 0) @(negedge clk);
    got = reply_q.pop_front();
    compare_value(name, 32'(exp), 32'(got));
  endtask

  task automatic expect_silence(input string what);
    repeat (20 * CLKS_PER_BIT) @(negedge clk);
    checks++;
    if (reply_q.size() != 0) begin
      errors++;
      $display("Unexpected reply bytes on tx_o after %s", what);
      reply_q.delete();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host receiver, APB slave and monitors
  ////////////////////////////////////////////////////////////////////////////

  // Samples tx mid-bit on the falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (arst_n === 1'b1 && tx === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          mon_byte[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1) begin
          errors++;
          $display("Reply frame on tx_o ended without a stop bit");
        end
        reply_q.push_back(mon_byte);
      end
    end
  end

  // Random 0 to 3 wait states per access
  initial begin
    apb_rsp = '0;
    forever begin
      @(posedge clk);
      #10;
      apb_rsp.pready = 1'b0;
      if (apb_req.psel && !apb_req.penable) begin
        apb_access_cnt++;
        wait_left = int'(lcg_next() >> 30);
      end else if (apb_req.psel && apb_req.penable) begin
        if (wait_left > 0) begin
          wait_left--;
        end else begin
          apb_rsp.pready = 1'b1;
          if (apb_req.pwrite) begin
            slave_mem[apb_req.paddr] = apb_req.pwdata;
            wlog_addr.push_back(apb_req.paddr);
            wlog_data.push_back(apb_req.pwdata);
          end else if (slave_mem.exists(apb_req.paddr)) begin
            apb_rsp.prdata = slave_mem[apb_req.paddr];
          end else begin
            apb_rsp.prdata = fill_byte(apb_req.paddr);
          end
        end
      end
    end
  end

  always @(negedge clk) begin
    if (arst_n === 1'b1 && exec_valid === 1'b1) begin
      exec_pulses++;
      exec_addr_seen = exec_addr;
    end
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_limit > 0);
    wait (cycle_cnt >= cycle_limit);
    $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rx        = 1'b1;
    eoc       = 1'b0;
    exit_code = '0;
    wr_addr   = lcg_next();
    rnd       = lcg_next();
    wr_len    = int'(rnd[19:16]) + 1;
    for (int i = 0; i < 16; i++) begin
      rnd        = lcg_next();
      wr_data[i] = rnd[23:16];
    end
    exec_target = lcg_next();
    code        = lcg_next();
    bad_cmd     = pick_unknown_cmd();
    // Sent 22 + len bytes and expected 12 + len bytes
    cycle_limit = 10 * CLKS_PER_BIT * (34 + 2 * wr_len) * 2 + 1000;

    wait (arst_n === 1'b1);
    @(negedge clk);
    compare_value("tx_o", 32'h1, 32'(tx));
    compare_value("psel", 32'h0, 32'(apb_req.psel));
    compare_value("exec_valid_o", 32'h0, 32'(exec_valid));

    // Lone acknowledge challenge
    send_byte(BYTE_ACK);
    expect_byte("tx_o ack", BYTE_ACK);
    expect_silence("the acknowledge reply");

    // Write burst
    send_byte(CMD_WRITE);
    send_field(wr_addr, ADDR_BYTES);
    send_field(32'(wr_len), LEN_BYTES);
    for (int i = 0; i < wr_len; i++) begin
      send_byte(wr_data[i]);
      ref_mem[wr_addr + 32'(i)] = wr_data[i];
    end
    expect_byte("tx_o write ack", BYTE_ACK);
    expect_byte("tx_o write eot", BYTE_EOT);
    checks++;
    if (wlog_addr.size() != wr_len) begin
      errors++;
      $display("APB saw %0d writes where %0d were sent", wlog_addr.size(), wr_len);
    end else begin
      for (int i = 0; i < wr_len; i++) begin
        compare_value("paddr", wr_addr + 32'(i), wlog_addr[i]);
        compare_value("pwdata", 32'(wr_data[i]), 32'(wlog_data[i]));
      end
    end

    // Read back the same region
    send_byte(CMD_READ);
    send_field(wr_addr, ADDR_BYTES);
    send_field(32'(wr_len), LEN_BYTES);
    expect_byte("tx_o read ack", BYTE_ACK);
    for (int i = 0; i < wr_len; i++) begin
      expect_byte("tx_o read data", ref_mem[wr_addr + 32'(i)]);
    end
    expect_byte("tx_o read eot", BYTE_EOT);

    // Execute
    send_byte(CMD_EXEC);
    send_field(exec_target, ADDR_BYTES);
    expect_byte("tx_o exec ack", BYTE_ACK);
    checks++;
    if (exec_pulses != 1) begin
      errors++;
      $display("exec_valid_o pulsed %0d times for one execute command", exec_pulses);
    end
    compare_value("exec_addr_o", exec_target, exec_addr_seen);

    // End of computation, the code input changes once the pulse is over
    @(posedge clk);
    #10;
    eoc       = 1'b1;
    exit_code = code;
    @(posedge clk);
    #10;
    eoc       = 1'b0;
    exit_code = ~code;
    expect_byte("tx_o eoc", BYTE_EOC);
    for (int i = 0; i < EXIT_BYTES; i++) expect_byte("tx_o exit code", code[8*i +: 8]);

    // Unknown command is dropped silently
    access_before = apb_access_cnt;
    send_byte(bad_cmd);
    expect_silence("an unknown command byte");
    checks++;
    if (apb_access_cnt != access_before) begin
      errors++;
      $display("Unknown command byte started an APB access");
    end
    send_byte(BYTE_ACK);
    expect_byte("tx_o ack after unknown", BYTE_ACK);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* project.f */
src/uart_dbg_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/apb_byte_master.sv
src/dbg_cmd_engine.sv
src/uart_dbg_top.sv
testbench/tb_clk_gen.sv
testbench/tb_uart_dbg.sv

/* Makefile */
# Verilator flow for the UART debug loader

VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_uart_dbg
FILELIST  ?= project.f
LOG       ?= sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

# Pass only if the log holds the pass line
sim: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
